// File: rtl/mem_pipe_pkg.sv
package mem_pipe_pkg;

    typedef logic [31:0] word_t;     // data word or virtual address
    typedef logic [19:0] vpn_t;      // 4 KiB pages
    typedef logic [19:0] pfn_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [4:0]  exc_code_t;

    // exception codes as seen by the handler
    localparam exc_code_t EXC_NONE = 5'd0;
    localparam exc_code_t EXC_MOD  = 5'd1;
    localparam exc_code_t EXC_TLBL = 5'd2;
    localparam exc_code_t EXC_TLBS = 5'd3;
    localparam exc_code_t EXC_ADEL = 5'd4;
    localparam exc_code_t EXC_ADES = 5'd5;

    typedef enum logic [3:0] {
        OP_LB,
        OP_LBU,
        OP_LH,
        OP_LHU,
        OP_LW,
        OP_LWL,
        OP_LWR,
        OP_SB,
        OP_SH,
        OP_SW
    } mem_op_e;

    typedef struct packed {
        vpn_t vpn;
        pfn_t pfn;
        logic v;    // page valid
        logic d;    // dirty, page writable
    } tlb_entry_t;

    typedef struct packed {
        mem_op_e         op;
        word_t           base;
        logic signed [15:0] offset;
        word_t           rt_value;  // store data or old rt for lwl/lwr
        reg_idx_t        dest;
    } issue_t;

    typedef struct packed {
        mem_op_e  op;
        word_t    vaddr;
        word_t    rt_value;
        reg_idx_t dest;
        logic     mapped;
        logic     tlb_found;
        logic     tlb_v;
        logic     tlb_d;
        logic     adr_err;
    } as_to_ms_t;

    typedef struct packed {
        logic      ex;
        exc_code_t exc_code;
        logic      tlb_refill;  // refill vector instead of general one
        logic      gr_we;
        reg_idx_t  dest;
        word_t     result;
        word_t     badvaddr;
    } ms_out_t;

    function automatic logic is_store(input mem_op_e op);
        return (op == OP_SB) || (op == OP_SH) || (op == OP_SW);
    endfunction

endpackage

// File: rtl/tlb_lookup.sv
module tlb_lookup #(
    parameter int TLB_ENTRIES = 8
) (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           we,
    input  logic [$clog2(TLB_ENTRIES)-1:0] windex,
    input  mem_pipe_pkg::tlb_entry_t       wentry,
    input  mem_pipe_pkg::vpn_t             qvpn,
    output logic                           found,
    output mem_pipe_pkg::tlb_entry_t       qentry
);

    localparam int IDX_W = $clog2(TLB_ENTRIES);

    mem_pipe_pkg::tlb_entry_t entries [TLB_ENTRIES];
    logic [TLB_ENTRIES-1:0]   written;   // entry has been filled since reset
    logic [TLB_ENTRIES-1:0]   match;
    logic [IDX_W-1:0]         hit_idx;

    // entry contents, written by software
    always_ff @(posedge clk) begin
        if (we && (windex < TLB_ENTRIES)) begin
            entries[windex] <= wentry;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            written <= '0;
        end else if (we && (windex < TLB_ENTRIES)) begin
            written[windex] <= 1'b1;
        end
    end

    // fully associative compare
    always_comb begin
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            match[i] = written[i] && (entries[i].vpn == qvpn);
        end
    end

    // encode the hit, software keeps vpns unique
    always_comb begin
        hit_idx = '0;
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            if (match[i]) begin
                hit_idx = IDX_W'(i);
            end
        end
    end

    assign found  = |match;
    assign qentry = found ? entries[hit_idx] : '0;  // no stale flags on a miss

    // duplicate vpns would make the hit index meaningless
    assert property (@(posedge clk) disable iff (reset) $onehot0(match))
        else $error("tlb: more than one entry matches vpn %h", qvpn);

endmodule

// File: rtl/data_ram.sv
module data_ram #(
    parameter int RAM_WORDS = 1024
) (
    input  logic                clk,
    input  logic                en,
    input  logic [3:0]          wstrb,
    input  mem_pipe_pkg::word_t addr,   // physical byte address
    input  mem_pipe_pkg::word_t wdata,
    output mem_pipe_pkg::word_t rdata
);

    localparam int IDX_W = $clog2(RAM_WORDS);

    mem_pipe_pkg::word_t mem [RAM_WORDS];
    logic [IDX_W-1:0]    idx;

    // word index, upper physical bits wrap
    assign idx = addr[2 +: IDX_W];

    // read sees the old word on a same-address write
    always_ff @(posedge clk) begin
        if (en) begin
            rdata <= mem[idx];
        end
    end

    // one write enable per byte lane
    always_ff @(posedge clk) begin
        if (en) begin
            for (int b = 0; b < 4; b++) begin
                if (wstrb[b]) begin
                    mem[idx][8*b +: 8] <= wdata[8*b +: 8];
                end
            end
        end
    end

endmodule

// File: rtl/addr_stage.sv
module addr_stage (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      flush,
    input  logic                      in_valid,
    input  mem_pipe_pkg::issue_t      in_req,
    output logic                      in_allowin,
    output logic                      as_valid,
    output mem_pipe_pkg::as_to_ms_t   as_bus,
    input  logic                      ms_allowin,
    output mem_pipe_pkg::vpn_t        tlb_qvpn,
    input  logic                      tlb_found,
    input  mem_pipe_pkg::tlb_entry_t  tlb_entry,
    output logic                      ram_en,
    output logic [3:0]                ram_wstrb,
    output mem_pipe_pkg::word_t       ram_addr,
    output mem_pipe_pkg::word_t       ram_wdata
);

    logic                   valid_r;
    mem_pipe_pkg::mem_op_e  op_r;
    mem_pipe_pkg::word_t    vaddr_r;
    mem_pipe_pkg::word_t    rt_r;
    mem_pipe_pkg::reg_idx_t dest_r;
    mem_pipe_pkg::word_t    eff_addr;
    logic                   mapped;
    logic                   adr_err;
    logic                   store;
    logic                   fault;
    logic [3:0]             lane_mask;

    assign eff_addr   = in_req.base + {{16{in_req.offset[15]}}, in_req.offset};
    assign in_allowin = !valid_r || ms_allowin;  // empty or draining into mem_stage
    assign as_valid   = valid_r;

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_r <= 1'b0;
        end else if (flush) begin
            valid_r <= 1'b0;
        end else if (in_allowin) begin
            valid_r <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_allowin) begin
            op_r    <= in_req.op;
            vaddr_r <= eff_addr;
            rt_r    <= in_req.rt_value;
            dest_r  <= in_req.dest;
        end
    end

    // kseg0/kseg1 bypass the tlb
    assign mapped   = (vaddr_r[31:30] != 2'b10);
    assign tlb_qvpn = vaddr_r[31:12];
    assign store    = mem_pipe_pkg::is_store(op_r);

    always_comb begin
        case (op_r)
            mem_pipe_pkg::OP_LH,
            mem_pipe_pkg::OP_LHU,
            mem_pipe_pkg::OP_SH: adr_err = vaddr_r[0];
            mem_pipe_pkg::OP_LW,
            mem_pipe_pkg::OP_SW: adr_err = |vaddr_r[1:0];
            default:             adr_err = 1'b0;  // byte ops and lwl/lwr
        endcase
    end

    assign fault = adr_err ||
                   (mapped && (!tlb_found || !tlb_entry.v || (store && !tlb_entry.d)));

    // lane select and data replication
    always_comb begin
        case (op_r)
            mem_pipe_pkg::OP_SB: begin
                lane_mask = 4'b0001 << vaddr_r[1:0];
                ram_wdata = {4{rt_r[7:0]}};
            end
            mem_pipe_pkg::OP_SH: begin
                lane_mask = vaddr_r[1] ? 4'b1100 : 4'b0011;
                ram_wdata = {2{rt_r[15:0]}};
            end
            default: begin
                lane_mask = 4'b1111;
                ram_wdata = rt_r;
            end
        endcase
    end

    assign ram_en    = valid_r && ms_allowin;
    assign ram_wstrb = (ram_en && store && !fault && !flush) ? lane_mask : 4'b0000;
    assign ram_addr  = mapped ? {tlb_entry.pfn, vaddr_r[11:0]} : {3'b000, vaddr_r[28:0]};

    always_comb begin
        as_bus.op        = op_r;
        as_bus.vaddr     = vaddr_r;
        as_bus.rt_value  = rt_r;
        as_bus.dest      = dest_r;
        as_bus.mapped    = mapped;
        as_bus.tlb_found = tlb_found;
        as_bus.tlb_v     = tlb_entry.v;
        as_bus.tlb_d     = tlb_entry.d;
        as_bus.adr_err   = adr_err;
    end

    // only an aligned store to kseg or a valid dirty page may write
    assert property (@(posedge clk) disable iff (reset)
        (ram_wstrb != 4'b0000) |-> (valid_r && ms_allowin && !flush &&
            (op_r inside {mem_pipe_pkg::OP_SB, mem_pipe_pkg::OP_SH, mem_pipe_pkg::OP_SW}) &&
            !((op_r == mem_pipe_pkg::OP_SH) && vaddr_r[0]) &&
            !((op_r == mem_pipe_pkg::OP_SW) && (vaddr_r[1:0] != 2'b00)) &&
            ((vaddr_r[31:30] == 2'b10) || (tlb_found && tlb_entry.v && tlb_entry.d))))
        else $error("addr_stage: write strobe on faulting or flushed op");

endmodule

// File: rtl/mem_stage.sv
module mem_stage (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     flush,
    input  logic                     as_valid,
    input  mem_pipe_pkg::as_to_ms_t  as_bus,
    output logic                     ms_allowin,
    input  mem_pipe_pkg::word_t      ram_rdata,
    output logic                     out_valid,
    output mem_pipe_pkg::ms_out_t    out_bus,
    input  logic                     out_allowin,
    output logic                     fwd_valid,
    output mem_pipe_pkg::reg_idx_t   fwd_dest,
    output mem_pipe_pkg::word_t      fwd_result
);

    logic                      valid_r;
    logic                      first_r;      // op arrived last edge, ram data live
    mem_pipe_pkg::as_to_ms_t   bus_r;
    mem_pipe_pkg::word_t       hold_r;
    mem_pipe_pkg::word_t       load_val;
    mem_pipe_pkg::word_t       load_result;
    mem_pipe_pkg::word_t       rt;
    mem_pipe_pkg::exc_code_t   exc_code;
    logic                      tlb_refill;
    logic                      store;
    logic                      ex;
    logic                      gr_we;
    logic [1:0]                byte_sel;
    logic [7:0]                ld_byte;
    logic [15:0]               ld_half;

    assign ms_allowin = !valid_r || out_allowin;
    assign out_valid  = valid_r;

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_r <= 1'b0;
            first_r <= 1'b0;
        end else if (flush) begin
            valid_r <= 1'b0;
            first_r <= 1'b0;
        end else begin
            if (ms_allowin) begin
                valid_r <= as_valid;
            end
            first_r <= as_valid && ms_allowin;
        end
    end

    always_ff @(posedge clk) begin
        if (as_valid && ms_allowin) begin
            bus_r <= as_bus;
        end
        if (first_r) begin
            hold_r <= load_val;  // ram output is gone after this cycle
        end
    end

    assign byte_sel = bus_r.vaddr[1:0];
    assign rt       = bus_r.rt_value;
    assign ld_byte  = ram_rdata[8*byte_sel +: 8];
    assign ld_half  = byte_sel[1] ? ram_rdata[31:16] : ram_rdata[15:0];

    // little endian extraction
    always_comb begin
        case (bus_r.op)
            mem_pipe_pkg::OP_LB:  load_val = {{24{ld_byte[7]}}, ld_byte};
            mem_pipe_pkg::OP_LBU: load_val = {24'd0, ld_byte};
            mem_pipe_pkg::OP_LH:  load_val = {{16{ld_half[15]}}, ld_half};
            mem_pipe_pkg::OP_LHU: load_val = {16'd0, ld_half};
            mem_pipe_pkg::OP_LWL: begin
                case (byte_sel)
                    2'd0:    load_val = {ram_rdata[7:0], rt[23:0]};
                    2'd1:    load_val = {ram_rdata[15:0], rt[15:0]};
                    2'd2:    load_val = {ram_rdata[23:0], rt[7:0]};
                    default: load_val = ram_rdata;
                endcase
            end
            mem_pipe_pkg::OP_LWR: begin
                case (byte_sel)
                    2'd0:    load_val = ram_rdata;
                    2'd1:    load_val = {rt[31:24], ram_rdata[31:8]};
                    2'd2:    load_val = {rt[31:16], ram_rdata[31:16]};
                    default: load_val = {rt[31:8], ram_rdata[31:24]};
                endcase
            end
            default: load_val = ram_rdata;  // lw, stores masked later
        endcase
    end

    assign load_result = first_r ? load_val : hold_r;
    assign store       = mem_pipe_pkg::is_store(bus_r.op);

    // address error first, then refill, invalid, modify
    always_comb begin
        exc_code   = mem_pipe_pkg::EXC_NONE;
        tlb_refill = 1'b0;
        if (bus_r.adr_err) begin
            exc_code = store ? mem_pipe_pkg::EXC_ADES : mem_pipe_pkg::EXC_ADEL;
        end else if (bus_r.mapped && !bus_r.tlb_found) begin
            exc_code   = store ? mem_pipe_pkg::EXC_TLBS : mem_pipe_pkg::EXC_TLBL;
            tlb_refill = 1'b1;
        end else if (bus_r.mapped && !bus_r.tlb_v) begin
            exc_code = store ? mem_pipe_pkg::EXC_TLBS : mem_pipe_pkg::EXC_TLBL;
        end else if (bus_r.mapped && store && !bus_r.tlb_d) begin
            exc_code = mem_pipe_pkg::EXC_MOD;
        end
    end

    assign ex    = (exc_code != mem_pipe_pkg::EXC_NONE);
    assign gr_we = !store && !ex;

    always_comb begin
        out_bus.ex         = ex;
        out_bus.exc_code   = exc_code;
        out_bus.tlb_refill = tlb_refill;
        out_bus.gr_we      = gr_we;
        out_bus.dest       = bus_r.dest;
        out_bus.result     = gr_we ? load_result : '0;  // zero unless rf write
        out_bus.badvaddr   = ex ? bus_r.vaddr : '0;
    end

    // bypass to decode
    assign fwd_valid  = valid_r && gr_we;
    assign fwd_dest   = bus_r.dest;
    assign fwd_result = out_bus.result;

    assert property (@(posedge clk) disable iff (reset)
        (out_valid && !out_allowin && !flush) |=> (out_valid && $stable(out_bus)))
        else $error("mem_stage: out_bus changed while stalled");

endmodule

// File: rtl/mem_pipe_top.sv
module mem_pipe_top #(
    parameter int TLB_ENTRIES = 8,
    parameter int RAM_WORDS   = 1024
) (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           flush,
    input  logic                           in_valid,
    input  mem_pipe_pkg::issue_t           in_req,
    output logic                           in_allowin,
    output logic                           out_valid,
    output mem_pipe_pkg::ms_out_t          out_bus,
    input  logic                           out_allowin,
    input  logic                           tlb_we,
    input  logic [$clog2(TLB_ENTRIES)-1:0] tlb_index,
    input  mem_pipe_pkg::tlb_entry_t       tlb_wentry,
    output logic                           fwd_valid,
    output mem_pipe_pkg::reg_idx_t         fwd_dest,
    output mem_pipe_pkg::word_t            fwd_result
);

    logic                     as_valid;
    logic                     ms_allowin;
    mem_pipe_pkg::as_to_ms_t  as_bus;
    mem_pipe_pkg::vpn_t       tlb_qvpn;
    logic                     tlb_found;
    mem_pipe_pkg::tlb_entry_t tlb_qentry;
    logic                     ram_en;
    logic [3:0]               ram_wstrb;
    mem_pipe_pkg::word_t      ram_addr;
    mem_pipe_pkg::word_t      ram_wdata;
    mem_pipe_pkg::word_t      ram_rdata;

    addr_stage u_addr_stage (
        .clk        (clk),
        .reset      (reset),
        .flush      (flush),
        .in_valid   (in_valid),
        .in_req     (in_req),
        .in_allowin (in_allowin),
        .as_valid   (as_valid),
        .as_bus     (as_bus),
        .ms_allowin (ms_allowin),
        .tlb_qvpn   (tlb_qvpn),
        .tlb_found  (tlb_found),
        .tlb_entry  (tlb_qentry),
        .ram_en     (ram_en),
        .ram_wstrb  (ram_wstrb),
        .ram_addr   (ram_addr),
        .ram_wdata  (ram_wdata)
    );

    tlb_lookup #(.TLB_ENTRIES(TLB_ENTRIES)) u_tlb_lookup (
        .clk    (clk),
        .reset  (reset),
        .we     (tlb_we),
        .windex (tlb_index),
        .wentry (tlb_wentry),
        .qvpn   (tlb_qvpn),
        .found  (tlb_found),
        .qentry (tlb_qentry)
    );

    data_ram #(.RAM_WORDS(RAM_WORDS)) u_data_ram (
        .clk   (clk),
        .en    (ram_en),
        .wstrb (ram_wstrb),
        .addr  (ram_addr),
        .wdata (ram_wdata),
        .rdata (ram_rdata)
    );

    mem_stage u_mem_stage (
        .clk         (clk),
        .reset       (reset),
        .flush       (flush),
        .as_valid    (as_valid),
        .as_bus      (as_bus),
        .ms_allowin  (ms_allowin),
        .ram_rdata   (ram_rdata),
        .out_valid   (out_valid),
        .out_bus     (out_bus),
        .out_allowin (out_allowin),
        .fwd_valid   (fwd_valid),
        .fwd_dest    (fwd_dest),
        .fwd_result  (fwd_result)
    );

endmodule

// File: verif/mem_pipe_tb.sv
module mem_pipe_tb;

    localparam int TLB_N       = 8;
    localparam int RAM_WORDS   = 1024;
    localparam int N_INIT      = 64;    // one sw per word of the test window
    localparam int N_UNMAP     = 300;
    localparam int N_MAPPED    = 300;
    localparam int N_MISALIGN  = 150;
    localparam int N_FLUSH     = 20;    // rounds of one or two loads
    localparam int N_BP        = 300;
    localparam int TOTAL_OPS   = N_INIT + N_UNMAP + N_MAPPED + N_MISALIGN + 2 * N_FLUSH + N_BP;
    localparam int CYCLE_LIMIT = 4 * TOTAL_OPS + 200;
    localparam logic [19:0] VPN_BASE = 20'h00100;

    logic                               clk;
    logic                               reset;
    logic                               flush;
    logic                               in_valid;
    mem_pipe_pkg::issue_t               in_req;
    logic                               in_allowin;
    logic                               out_valid;
    mem_pipe_pkg::ms_out_t              out_bus;
    logic                               out_allowin;
    logic                               tlb_we;
    logic [$clog2(TLB_N)-1:0]           tlb_index;
    mem_pipe_pkg::tlb_entry_t           tlb_wentry;
    logic                               fwd_valid;
    mem_pipe_pkg::reg_idx_t             fwd_dest;
    mem_pipe_pkg::word_t                fwd_result;

    int                                 seed = 20140;
    int                                 cycle = 0;
    int                                 accept_count = 0;
    bit                                 bp_mode = 1'b0;   // random out_allowin
    bit                                 hold_out = 1'b0;  // out_allowin forced low
    mem_pipe_pkg::tlb_entry_t           tlb_model [TLB_N];
    mem_pipe_pkg::word_t                model_mem [RAM_WORDS];
    mem_pipe_pkg::ms_out_t              exp_q [$];
    int                                 acc_cycle_q [$];
    bit                                 timed_q [$];      // latency must be exact

    mem_pipe_top #(
        .TLB_ENTRIES (TLB_N),
        .RAM_WORDS   (RAM_WORDS)
    ) u_mem_pipe_top (
        .clk         (clk),
        .reset       (reset),
        .flush       (flush),
        .in_valid    (in_valid),
        .in_req      (in_req),
        .in_allowin  (in_allowin),
        .out_valid   (out_valid),
        .out_bus     (out_bus),
        .out_allowin (out_allowin),
        .tlb_we      (tlb_we),
        .tlb_index   (tlb_index),
        .tlb_wentry  (tlb_wentry),
        .fwd_valid   (fwd_valid),
        .fwd_dest    (fwd_dest),
        .fwd_result  (fwd_result)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic stop_on_fail();
        $display("SOME TESTS FAILED");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_word(input string name, input logic [31:0] want, input logic [31:0] got);
        assert (got === want) else begin
            $display("MISMATCH time=%0t %s expected %h got %h", $time, name, want, got);
            stop_on_fail();
        end
    endtask

    // reference model, result of an op decided when it is accepted
    task automatic model_accept(input mem_pipe_pkg::issue_t req,
                                output mem_pipe_pkg::ms_out_t want);
        mem_pipe_pkg::word_t     va;
        mem_pipe_pkg::word_t     pa;
        mem_pipe_pkg::word_t     m;
        mem_pipe_pkg::word_t     rt;
        mem_pipe_pkg::word_t     val;
        mem_pipe_pkg::pfn_t      pfn;
        mem_pipe_pkg::exc_code_t exc;
        logic                    st;
        logic                    mis;
        logic                    mapped;
        logic                    found;
        logic                    v;
        logic                    d;
        logic                    refill;
        int                      b;
        int                      idx;
        va  = req.base + {{16{req.offset[15]}}, req.offset};
        rt  = req.rt_value;
        st  = req.op inside {mem_pipe_pkg::OP_SB, mem_pipe_pkg::OP_SH, mem_pipe_pkg::OP_SW};
        mis = 1'b0;
        if (req.op inside {mem_pipe_pkg::OP_LH, mem_pipe_pkg::OP_LHU, mem_pipe_pkg::OP_SH}) begin
            mis = (va % 2) != 0;
        end else if (req.op inside {mem_pipe_pkg::OP_LW, mem_pipe_pkg::OP_SW}) begin
            mis = (va % 4) != 0;
        end
        mapped = !(va >= 32'h8000_0000 && va <= 32'hbfff_ffff);
        found  = 1'b0;
        pfn    = '0;
        v      = 1'b0;
        d      = 1'b0;
        for (int i = 0; i < TLB_N; i++) begin
            if (tlb_model[i].vpn == va[31:12]) begin
                found = 1'b1;
                pfn   = tlb_model[i].pfn;
                v     = tlb_model[i].v;
                d     = tlb_model[i].d;
            end
        end
        exc    = mem_pipe_pkg::EXC_NONE;
        refill = 1'b0;
        if (mis) begin
            exc = st ? mem_pipe_pkg::EXC_ADES : mem_pipe_pkg::EXC_ADEL;
        end else if (mapped && (!found || !v)) begin
            exc    = st ? mem_pipe_pkg::EXC_TLBS : mem_pipe_pkg::EXC_TLBL;
            refill = !found;
        end else if (mapped && st && !d) begin
            exc = mem_pipe_pkg::EXC_MOD;
        end
        pa  = mapped ? {pfn, va[11:0]} : (va & 32'h1fff_ffff);
        idx = (pa / 4) % RAM_WORDS;
        m   = model_mem[idx];
        b   = va % 4;
        val = '0;
        if (exc == mem_pipe_pkg::EXC_NONE) begin
            case (req.op)
                mem_pipe_pkg::OP_LB:  val = {{24{m[8*b+7]}}, m[8*b +: 8]};
                mem_pipe_pkg::OP_LBU: val = (m >> (8 * b)) & 32'h0000_00ff;
                mem_pipe_pkg::OP_LH:  val = {{16{m[8*b+15]}}, m[8*b +: 16]};
                mem_pipe_pkg::OP_LHU: val = (m >> (8 * b)) & 32'h0000_ffff;
                mem_pipe_pkg::OP_LW:  val = m;
                mem_pipe_pkg::OP_LWL: val = (m << (8 * (3 - b))) |
                                            (rt & (32'hffff_ffff >> (8 * (b + 1))));
                mem_pipe_pkg::OP_LWR: val = (m >> (8 * b)) | (rt & ~(32'hffff_ffff >> (8 * b)));
                mem_pipe_pkg::OP_SB:  model_mem[idx][8*b +: 8] = rt[7:0];
                mem_pipe_pkg::OP_SH:  model_mem[idx][8*b +: 16] = rt[15:0];
                default:              model_mem[idx] = rt;  // sw
            endcase
        end
        want.ex         = (exc != mem_pipe_pkg::EXC_NONE);
        want.exc_code   = exc;
        want.tlb_refill = refill;
        want.gr_we      = !st && !want.ex;
        want.dest       = req.dest;
        want.result     = want.gr_we ? val : '0;
        want.badvaddr   = want.ex ? va : '0;
    endtask

    // monitor, samples at the rising edge
    always @(posedge clk) begin : monitor
        mem_pipe_pkg::ms_out_t want;
        if (!reset) begin
            cycle++;
            if (cycle > CYCLE_LIMIT) begin
                $display("timeout: run went past %0d cycles", CYCLE_LIMIT);
                stop_on_fail();
            end
            if (out_valid && exp_q.size() > 0) begin  // bypass view of the held op
                check_word("fwd_valid", exp_q[0].gr_we, fwd_valid);
                if (exp_q[0].gr_we) begin
                    check_word("fwd_dest", exp_q[0].dest, fwd_dest);
                    check_word("fwd_result", exp_q[0].result, fwd_result);
                end
            end else begin
                check_word("fwd_valid", 0, fwd_valid);
            end
            if (out_valid && out_allowin) begin
                assert (exp_q.size() > 0) else begin
                    $display("result came out at time %0t with no op in flight", $time);
                    stop_on_fail();
                end
                want = exp_q.pop_front();
                check_word("out_bus.ex", want.ex, out_bus.ex);
                check_word("out_bus.exc_code", want.exc_code, out_bus.exc_code);
                check_word("out_bus.tlb_refill", want.tlb_refill, out_bus.tlb_refill);
                check_word("out_bus.gr_we", want.gr_we, out_bus.gr_we);
                check_word("out_bus.dest", want.dest, out_bus.dest);
                check_word("out_bus.result", want.result, out_bus.result);
                check_word("out_bus.badvaddr", want.badvaddr, out_bus.badvaddr);
                if (timed_q.pop_front()) begin
                    check_word("out_valid latency", 2, cycle - acc_cycle_q[0]);
                end
                void'(acc_cycle_q.pop_front());
            end
            if (flush) begin
                exp_q.delete();  // everything in flight is dropped
                acc_cycle_q.delete();
                timed_q.delete();
            end
            if (in_valid && in_allowin && !flush) begin
                model_accept(in_req, want);
                exp_q.push_back(want);
                acc_cycle_q.push_back(cycle);
                timed_q.push_back(!bp_mode && !hold_out);
                accept_count++;
            end
        end
    end

    task automatic tick();
        @(negedge clk);
        if (hold_out) begin
            out_allowin = 1'b0;
        end else if (bp_mode) begin
            out_allowin = ($random(seed) % 4) != 0;
        end else begin
            out_allowin = 1'b1;
        end
    endtask

    task automatic send(input mem_pipe_pkg::issue_t req);
        int n;
        n        = accept_count;
        in_req   = req;
        in_valid = 1'b1;
        while (accept_count == n) begin
            tick();
        end
        in_valid = 1'b0;
    endtask

    task automatic drain();
        while (exp_q.size() != 0) begin
            tick();
        end
    endtask

    task automatic make_op(input bit use_map, input bit misalign, input bit loads_only,
                           output mem_pipe_pkg::issue_t req);
        logic [7:0]          off8;
        mem_pipe_pkg::word_t va;
        int                  page;
        req.op = mem_pipe_pkg::mem_op_e'($unsigned($random(seed)) % (loads_only ? 7 : 10));
        off8   = $random(seed);
        if (!misalign) begin
            if (req.op inside {mem_pipe_pkg::OP_LH, mem_pipe_pkg::OP_LHU, mem_pipe_pkg::OP_SH}) begin
                off8[0] = 1'b0;
            end else if (req.op inside {mem_pipe_pkg::OP_LW, mem_pipe_pkg::OP_SW}) begin
                off8[1:0] = 2'b00;
            end
        end
        if (use_map) begin
            page = $unsigned($random(seed)) % (TLB_N + 4);  // last four pages miss
            va   = {VPN_BASE + 20'(page), 4'h0, off8};
        end else begin
            va = {2'b10, 1'($random(seed)), 17'($random(seed)), 4'h0, off8};
        end
        req.offset   = $random(seed);
        req.base     = va - {{16{req.offset[15]}}, req.offset};
        req.rt_value = $random(seed);
        req.dest     = $random(seed);
    endtask

    task automatic run_ops(input int n, input int map_sel, input int mis_sel);
        mem_pipe_pkg::issue_t req;
        for (int i = 0; i < n; i++) begin
            // sel 2 picks at random per op
            make_op(map_sel == 2 ? $random(seed) & 1 : map_sel,
                    mis_sel == 2 ? $random(seed) & 1 : mis_sel, 1'b0, req);
            send(req);
            if (($random(seed) & 7) == 0) begin
                tick();
            end
        end
    endtask

    task automatic flush_round();
        mem_pipe_pkg::issue_t req;
        int                   n_ld;
        n_ld     = 1 + ($unsigned($random(seed)) % 2);
        hold_out = 1'b1;  // keep the loads inside the pipe
        for (int i = 0; i < n_ld; i++) begin
            make_op($random(seed) & 1, 1'b0, 1'b1, req);
            send(req);
        end
        if ($random(seed) & 1) begin
            tick();
        end
        flush = 1'b1;
        tick();
        flush    = 1'b0;
        hold_out = 1'b0;
        tick();
    endtask

    initial begin : driver
        mem_pipe_pkg::issue_t     req;
        mem_pipe_pkg::tlb_entry_t ent;
        reset       = 1'b1;
        flush       = 1'b0;
        in_valid    = 1'b0;
        in_req      = '0;
        out_allowin = 1'b1;
        tlb_we      = 1'b0;
        tlb_index   = '0;
        tlb_wentry  = '0;
        repeat (16) @(negedge clk);
        reset = 1'b0;
        tick();
        check_word("in_allowin", 1, in_allowin);
        check_word("out_valid", 0, out_valid);
        check_word("fwd_valid", 0, fwd_valid);
        // entry 0 writable, 1 read only, 2 invalid, rest random
        for (int i = 0; i < TLB_N; i++) begin
            ent.vpn = VPN_BASE + 20'(i);
            ent.pfn = $random(seed);
            ent.v   = (i == 2) ? 1'b0 : (i < 2) ? 1'b1 : 1'($random(seed));
            ent.d   = (i == 0) ? 1'b1 : (i < 3) ? 1'b0 : 1'($random(seed));
            tlb_model[i] = ent;
            tlb_we       = 1'b1;
            tlb_index    = i;
            tlb_wentry   = ent;
            tick();
        end
        tlb_we = 1'b0;
        for (int i = 0; i < N_INIT; i++) begin  // fill the word window
            req.op       = mem_pipe_pkg::OP_SW;
            req.offset   = $random(seed);
            req.base     = 32'h8000_0000 + 4 * i - {{16{req.offset[15]}}, req.offset};
            req.rt_value = $random(seed);
            req.dest     = '0;
            send(req);
        end
        run_ops(N_UNMAP, 0, 0);
        run_ops(N_MAPPED, 1, 0);
        drain();
        bp_mode = 1'b1;
        run_ops(N_MISALIGN, 2, 1);
        drain();
        bp_mode = 1'b0;
        tick();
        for (int i = 0; i < N_FLUSH; i++) begin
            flush_round();
        end
        bp_mode = 1'b1;
        run_ops(N_BP, 2, 2);
        drain();
        repeat (4) tick();
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

// File: mem_pipe.f
rtl/mem_pipe_pkg.sv
rtl/tlb_lookup.sv
rtl/data_ram.sv
rtl/addr_stage.sv
rtl/mem_stage.sv
rtl/mem_pipe_top.sv
verif/mem_pipe_tb.sv
